// ==== filelist.f ====
+incdir+.
ft_alu_pkg.sv
tmr_voter.sv
alu_replica.sv
spare_mux.sv
vote_unit.sv
fault_tracker.sv
alu_ft_top.sv
alu_ft_chk.sv
tb_alu_ft.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the ALU stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
	--top-module tb_alu_ft -f filelist.f --Mdir "$OBJ" -o sim_alu_ft
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ/sim_alu_ft" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF "All tests passed!" "$LOG"; then
	exit 0
else
	echo "pass message not found in $LOG"
	exit 1
fi

// ==== tb_alu_ft.sv ====
/*
 * testbench for the fault-tolerant ALU stage
 * clock, reset, random stimulus, reference model, output checker, timeout
 */

`include "ft_alu_config.svh"

module tb_alu_ft;
	import ft_alu_pkg::*;

	localparam int SHW        = $clog2(`FT_DATA_WIDTH);
	localparam int N_RAND     = 60;
	localparam int N_MASK     = 20;
	localparam int N_SPARE    = 10;
	localparam int N_THRESH   = `FT_FAULT_THRESHOLD;
	localparam int N_CLEAN    = 4;
	localparam int N_BYP      = 12;
	localparam int N_TOTAL    = N_RAND + N_MASK + 2 * N_SPARE + N_THRESH + N_CLEAN + N_BYP;
	localparam int MAX_CYCLES = 4 * N_TOTAL + 100;

	// error flag expectation at each output transfer
	localparam int MODE_CLEAN     = 0;
	localparam int MODE_CORRECTED = 1;
	localparam int MODE_NONE      = 2;

	logic                        clk;
	logic                        rst_n;
	logic                        in_valid;
	logic                        in_ready;
	alu_op_e                     op;
	word_t                       operand_a;
	word_t                       operand_b;
	logic                        out_valid;
	logic                        out_ready;
	word_t                       result;
	logic                        cmp;
	word_t                       fault_mask [`FT_NUM_REPLICAS];
	logic [`FT_NUM_REPLICAS-1:0] fault_cmp;
	logic [`FT_NUM_SLOTS-1:0]    spare_sel;
	logic [1:0]                  bypass_sel;
	logic                        err_detected;
	logic                        err_corrected;
	replica_idx_t                cnt_addr;
	err_cnt_t                    cnt_rdata;
	logic [`FT_NUM_REPLICAS-1:0] permanent_fault;

	integer seed;
	int     errors;
	int     tests_run;
	int     tests_failed;
	int     test_err_base;
	int     xfers;
	int     cycles = 0;
	bit     bp_en;
	int     bp_rand;
	int     err_mode;

	// {cmp, result} per accepted operation in arrival order
	logic [`FT_DATA_WIDTH:0] exp_q [$];

	alu_ft_top i_dut (
		.clk(clk), .rst_n_i(rst_n),
		.in_valid_i(in_valid), .in_ready_o(in_ready),
		.op_i(op), .operand_a_i(operand_a), .operand_b_i(operand_b),
		.out_valid_o(out_valid), .out_ready_i(out_ready),
		.result_o(result), .cmp_o(cmp),
		.fault_mask_i(fault_mask), .fault_cmp_i(fault_cmp),
		.spare_sel_i(spare_sel), .bypass_sel_i(bypass_sel),
		.err_detected_o(err_detected), .err_corrected_o(err_corrected),
		.cnt_addr_i(cnt_addr), .cnt_rdata_o(cnt_rdata),
		.permanent_fault_o(permanent_fault)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	// result with the upset of the observed slot folded in
	function automatic logic [`FT_DATA_WIDTH:0] alu_ref(
		input alu_op_e op_v, input word_t a, input word_t b, input word_t mask
	);
		word_t r;
		logic  c;
		// equality unless a less-than op
		c = (a == b);
		case (op_v)
			ALU_ADD: r = a + b;
			ALU_SUB: r = a - b;
			ALU_AND: r = a & b;
			ALU_OR:  r = a | b;
			ALU_XOR: r = a ^ b;
			ALU_SLL: r = a << b[SHW-1:0];
			ALU_SRL: r = a >> b[SHW-1:0];
			ALU_SLT: begin
				c = $signed(a) < $signed(b);
				r = word_t'(c);
			end
			ALU_SLTU: begin
				c = a < b;
				r = word_t'(c);
			end
			default: r = '0;
		endcase
		return {c, r ^ mask};
	endfunction

	////////////////////////////////////////////////////////////
	// back-pressure, output checker, timeout
	////////////////////////////////////////////////////////////

	// ready draw happens away from the operand draws
	always @(negedge clk) begin
		bp_rand = $random(seed);
	end

	always @(posedge clk) begin
		#1;
		out_ready = bp_en ? bp_rand[0] : 1'b1;
	end

	// mid-cycle sample of a transfer that completes on the next edge
	always @(negedge clk) begin : compare_out
		logic [`FT_DATA_WIDTH:0] want;
		if (rst_n && out_valid && out_ready) begin
			xfers = xfers + 1;
			if (exp_q.size() == 0) begin
				$display("output transfer at %0t with no operation pending", $time);
				errors++;
			end else begin
				want = exp_q.pop_front();
				if (result !== want[`FT_DATA_WIDTH-1:0]) begin
					$display("error at %0t: result %h, expected %h",
						$time, result, want[`FT_DATA_WIDTH-1:0]);
					errors++;
				end
				if (cmp !== want[`FT_DATA_WIDTH]) begin
					$display("error at %0t: cmp %b, expected %b",
						$time, cmp, want[`FT_DATA_WIDTH]);
					errors++;
				end
			end
			if (err_mode == MODE_CLEAN && (err_detected || err_corrected)) begin
				$display("error at %0t: error flags %b%b on a clean transfer",
					$time, err_detected, err_corrected);
				errors++;
			end
			if (err_mode == MODE_CORRECTED && !(err_detected && err_corrected)) begin
				$display("error at %0t: single upset not flagged as corrected", $time);
				errors++;
			end
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, the DUT stopped making progress", cycles);
			$display("Test failures found");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus tasks
	////////////////////////////////////////////////////////////

	// hold one operation until accepted and queue its expected value
	task automatic issue_op(input alu_op_e op_v, input word_t a, input word_t b);
		bit    acc;
		word_t mask;
		int    slot;
		in_valid  = 1'b1;
		op        = op_v;
		operand_a = a;
		operand_b = b;
		acc       = 1'b0;
		while (!acc) begin
			@(negedge clk);
			acc = in_ready;
			if (acc) begin
				mask = '0;
				// raw slot shows the upset of whichever replica feeds it
				if (bypass_sel != 2'd0) begin
					slot = int'(bypass_sel) - 1;
					mask = spare_sel[slot] ? fault_mask[`FT_NUM_REPLICAS-1] : fault_mask[slot];
				end
				exp_q.push_back(alu_ref(op_v, a, b, mask));
			end
			@(posedge clk);
			#1;
		end
		in_valid = 1'b0;
	endtask

	task automatic random_ops(input int n);
		int unsigned r;
		word_t       a;
		word_t       b;
		for (int i = 0; i < n; i++) begin
			r = $random(seed);
			a = $random(seed);
			// equal operands now and then for the compare flag
			b = (r[6:4] == 3'd0) ? a : $random(seed);
			issue_op(alu_op_e'(4'(r % 9)), a, b);
		end
	endtask

	task automatic drain();
		while (exp_q.size() != 0) @(posedge clk);
		repeat (2) @(posedge clk);
		#1;
	endtask

	// registered read port with one edge of latency
	task automatic read_cnt(input int idx, output int val);
		cnt_addr = replica_idx_t'(idx);
		@(posedge clk);
		@(negedge clk);
		val = int'(cnt_rdata);
		@(posedge clk);
		#1;
	endtask

	task automatic begin_test();
		test_err_base = errors;
		xfers = 0;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors != test_err_base) begin
			tests_failed++;
			$display("test %s: FAIL, %0d errors", name, errors - test_err_base);
		end else begin
			$display("test %s: ok, %0d transfers", name, xfers);
		end
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin : main
		int c0;
		int c1;
		seed         = 16;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		bp_en        = 1'b0;
		bp_rand      = 0;
		err_mode     = MODE_CLEAN;
		rst_n        = 1'b0;
		in_valid     = 1'b0;
		op           = ALU_ADD;
		operand_a    = '0;
		operand_b    = '0;
		out_ready    = 1'b1;
		fault_cmp    = '0;
		spare_sel    = '0;
		bypass_sel   = 2'd0;
		cnt_addr     = '0;
		for (int r = 0; r < `FT_NUM_REPLICAS; r++) begin
			fault_mask[r] = '0;
		end
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// reset state
		begin_test();
		@(negedge clk);
		if (out_valid || err_detected || err_corrected || permanent_fault != '0) begin
			$display("error at %0t: outputs or flags not clear after reset", $time);
			errors++;
		end
		@(posedge clk);
		#1;
		for (int r = 0; r < `FT_NUM_REPLICAS; r++) begin
			read_cnt(r, c0);
			if (c0 != 0) begin
				$display("error at %0t: counter %0d reads %0d after reset", $time, r, c0);
				errors++;
			end
		end
		end_test("reset state");

		// fault-free traffic under back-pressure
		bp_en = 1'b1;
		begin_test();
		random_ops(N_RAND);
		drain();
		for (int r = 0; r < `FT_NUM_REPLICAS; r++) begin
			read_cnt(r, c0);
			if (c0 != 0) begin
				$display("error at %0t: counter %0d reads %0d without faults", $time, r, c0);
				errors++;
			end
		end
		end_test("random ops without faults");

		// upset on replica 1 gets outvoted
		fault_mask[1] = $random(seed) | 1;
		err_mode = MODE_CORRECTED;
		begin_test();
		random_ops(N_MASK);
		drain();
		fault_mask[1] = '0;
		read_cnt(1, c1);
		if (c1 != N_MASK) begin
			$display("error at %0t: counter 1 reads %0d, expected %0d", $time, c1, N_MASK);
			errors++;
		end
		end_test("masked replica 1");

		// standby replaces replica 1 whose upsets stay invisible
		spare_sel = 3'b010;
		fault_mask[1] = $random(seed) | 1;
		err_mode = MODE_CLEAN;
		begin_test();
		random_ops(N_SPARE);
		drain();
		fault_mask[1] = '0;
		read_cnt(1, c1);
		if (c1 != N_MASK) begin
			$display("error at %0t: counter 1 reads %0d, expected %0d", $time, c1, N_MASK);
			errors++;
		end
		end_test("retired replica 1");

		// upsets on the standby go to counter 3
		fault_mask[`FT_NUM_REPLICAS-1] = $random(seed) | 1;
		err_mode = MODE_CORRECTED;
		begin_test();
		random_ops(N_SPARE);
		drain();
		fault_mask[`FT_NUM_REPLICAS-1] = '0;
		read_cnt(3, c1);
		if (c1 != N_SPARE) begin
			$display("error at %0t: counter 3 reads %0d, expected %0d", $time, c1, N_SPARE);
			errors++;
		end
		spare_sel = '0;
		end_test("standby credited");

		// replica 0 reaches the threshold and its flag outlives the fault
		fault_mask[0] = $random(seed) | 1;
		begin_test();
		random_ops(N_THRESH);
		drain();
		fault_mask[0] = '0;
		read_cnt(0, c1);
		if (c1 != N_THRESH) begin
			$display("error at %0t: counter 0 reads %0d, expected %0d", $time, c1, N_THRESH);
			errors++;
		end
		if (!permanent_fault[0]) begin
			$display("error at %0t: permanent flag 0 low at the threshold", $time);
			errors++;
		end
		err_mode = MODE_CLEAN;
		random_ops(N_CLEAN);
		drain();
		if (!permanent_fault[0]) begin
			$display("error at %0t: permanent flag 0 dropped after the fault was removed",
				$time);
			errors++;
		end
		end_test("permanent fault");

		// second slot passed raw so the upset of replica 1 reaches the output
		bypass_sel = 2'd2;
		fault_mask[1] = $random(seed) | 1;
		err_mode = MODE_NONE;
		begin_test();
		random_ops(N_BYP);
		drain();
		bypass_sel = 2'd0;
		fault_mask[1] = '0;
		end_test("bypass slot 2");

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== alu_ft_chk.sv ====
/*
 * bound assertions on the ALU stage top level
 * reset, output stall and sticky fault flags
 */

`include "ft_alu_config.svh"

module alu_ft_chk (
	input logic                        clk,
	input logic                        rst_n_i,
	input logic                        out_valid_i,
	input logic                        out_ready_i,
	input ft_alu_pkg::word_t           result_i,
	input logic [`FT_NUM_REPLICAS-1:0] perm_fault_i
);

	// output register empty while reset is held
	a_reset_valid: assert property (@(posedge clk) !rst_n_i |-> !out_valid_i)
		else $error("out_valid_o high during reset");

	// stalled item holds its value
	a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
		out_valid_i && !out_ready_i |=> out_valid_i && $stable(result_i))
		else $error("result_o changed under back-pressure");

	// no flag may clear before reset
	a_perm_sticky: assert property (@(posedge clk) disable iff (!rst_n_i)
		(($past(perm_fault_i) & ~perm_fault_i) == '0))
		else $error("permanent fault flag fell");

endmodule

bind alu_ft_top alu_ft_chk i_chk (
	.clk(clk), .rst_n_i(rst_n_i),
	.out_valid_i(out_valid_o), .out_ready_i(out_ready_i),
	.result_i(result_o), .perm_fault_i(permanent_fault_o)
);

// ==== alu_ft_top.sv ====
/*
 * fault-tolerant ALU stage top level
 * four replicas, spare mux, vote unit, fault tracker
 */

`include "ft_alu_config.svh"

module alu_ft_top (
	input  logic                           clk,
	input  logic                           rst_n_i,
	input  logic                           in_valid_i,
	output logic                           in_ready_o,
	input  ft_alu_pkg::alu_op_e            op_i,
	input  ft_alu_pkg::word_t              operand_a_i,
	input  ft_alu_pkg::word_t              operand_b_i,
	output logic                           out_valid_o,
	input  logic                           out_ready_i,
	output ft_alu_pkg::word_t              result_o,
	output logic                           cmp_o,
	input  ft_alu_pkg::word_t              fault_mask_i [`FT_NUM_REPLICAS],
	input  logic [`FT_NUM_REPLICAS-1:0]    fault_cmp_i,
	input  logic [`FT_NUM_SLOTS-1:0]       spare_sel_i,
	input  logic [1:0]                     bypass_sel_i,
	output logic                           err_detected_o,
	output logic                           err_corrected_o,
	input  ft_alu_pkg::replica_idx_t       cnt_addr_i,
	output ft_alu_pkg::err_cnt_t           cnt_rdata_o,
	output logic [`FT_NUM_REPLICAS-1:0]    permanent_fault_o
);
	import ft_alu_pkg::*;

	// replica outputs
	word_t                       rep_result [`FT_NUM_REPLICAS];
	logic [`FT_NUM_REPLICAS-1:0] rep_cmp;
	logic [`FT_NUM_REPLICAS-1:0] rep_valid;
	logic [`FT_NUM_REPLICAS-1:0] rep_ready;

	// voting slots
	word_t                       slot_result [`FT_NUM_SLOTS];
	logic [`FT_NUM_SLOTS-1:0]    slot_cmp;
	logic [`FT_NUM_SLOTS-1:0]    slot_valid;
	logic [`FT_NUM_SLOTS-1:0]    slot_ready;
	logic [`FT_NUM_SLOTS-1:0]    slot_err;
	logic                        transfer;

	////////////////////////////////////////////////////////////
	// replicas
	////////////////////////////////////////////////////////////

	// same operation broadcast to every replica
	for (genvar r = 0; r < `FT_NUM_REPLICAS; r++) begin : g_rep
		alu_replica i_rep (
			.clk(clk), .rst_n_i(rst_n_i),
			.in_valid_i(in_valid_i), .in_ready_o(rep_ready[r]),
			.op_i(op_i), .operand_a_i(operand_a_i), .operand_b_i(operand_b_i),
			.fault_mask_i(fault_mask_i[r]), .fault_cmp_i(fault_cmp_i[r]),
			.out_valid_o(rep_valid[r]), .out_ready_i(out_ready_i),
			.result_o(rep_result[r]), .cmp_o(rep_cmp[r])
		);
	end

	////////////////////////////////////////////////////////////
	// slot selection, voting, tracking
	////////////////////////////////////////////////////////////

	spare_mux i_spare (
		.spare_sel_i(spare_sel_i),
		.result_i(rep_result), .cmp_i(rep_cmp), .valid_i(rep_valid), .ready_i(rep_ready),
		.slot_result_o(slot_result), .slot_cmp_o(slot_cmp),
		.slot_valid_o(slot_valid), .slot_ready_o(slot_ready)
	);

	vote_unit i_vote (
		.slot_result_i(slot_result), .slot_cmp_i(slot_cmp),
		.slot_valid_i(slot_valid), .slot_ready_i(slot_ready),
		.bypass_sel_i(bypass_sel_i),
		.result_o(result_o), .cmp_o(cmp_o),
		.out_valid_o(out_valid_o), .in_ready_o(in_ready_o),
		.slot_err_o(slot_err),
		.err_detected_o(err_detected_o), .err_corrected_o(err_corrected_o)
	);

	// downstream handshake completes
	assign transfer = out_valid_o & out_ready_i;

	fault_tracker i_track (
		.clk(clk), .rst_n_i(rst_n_i),
		.spare_sel_i(spare_sel_i), .slot_err_i(slot_err), .transfer_i(transfer),
		.cnt_addr_i(cnt_addr_i), .cnt_rdata_o(cnt_rdata_o),
		.permanent_fault_o(permanent_fault_o)
	);

endmodule

// ==== fault_tracker.sv ====
/*
 * per-replica error counters with saturation
 * sticky permanent-fault flags, registered read port
 */

`include "ft_alu_config.svh"

module fault_tracker (
	input  logic                           clk,
	input  logic                           rst_n_i,
	input  logic [`FT_NUM_SLOTS-1:0]       spare_sel_i,
	input  logic [`FT_NUM_SLOTS-1:0]       slot_err_i,
	input  logic                           transfer_i,
	input  ft_alu_pkg::replica_idx_t       cnt_addr_i,
	output ft_alu_pkg::err_cnt_t           cnt_rdata_o,
	output logic [`FT_NUM_REPLICAS-1:0]    permanent_fault_o
);
	import ft_alu_pkg::*;

	localparam int SPARE = `FT_NUM_REPLICAS - 1;

	logic [`FT_NUM_REPLICAS-1:0] credit;
	err_cnt_t                    cnt_q [`FT_NUM_REPLICAS];
	err_cnt_t                    rdata_q;
	logic [`FT_NUM_REPLICAS-1:0] perm_q;

	////////////////////////////////////////////////////////////
	// slot to replica crediting
	////////////////////////////////////////////////////////////

	// idle standby gets nothing
	always_comb begin
		credit = '0;
		for (int k = 0; k < `FT_NUM_SLOTS; k++) begin
			if (slot_err_i[k]) begin
				if (spare_sel_i[k]) begin
					credit[SPARE] = 1'b1;
				end else begin
					credit[k] = 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// counters and permanent flags
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int r = 0; r < `FT_NUM_REPLICAS; r++) begin
				cnt_q[r] <= '0;
			end
			perm_q  <= '0;
			rdata_q <= '0;
		end else begin
			for (int r = 0; r < `FT_NUM_REPLICAS; r++) begin
				// count only on a real downstream transfer, hold at max
				if (transfer_i && credit[r] && cnt_q[r] != '1) begin
					cnt_q[r] <= cnt_q[r] + 1'b1;
				end
				// sticky until reset
				if (cnt_q[r] >= err_cnt_t'(`FT_FAULT_THRESHOLD)) begin
					perm_q[r] <= 1'b1;
				end
			end
			rdata_q <= cnt_q[cnt_addr_i];
		end
	end

	assign cnt_rdata_o       = rdata_q;
	assign permanent_fault_o = perm_q;

endmodule

// ==== vote_unit.sv ====
/*
 * voters for result, compare flag, valid and ready
 * bypass of a single raw slot, error summary flags
 */

`include "ft_alu_config.svh"

module vote_unit (
	input  ft_alu_pkg::word_t        slot_result_i [`FT_NUM_SLOTS],
	input  logic [`FT_NUM_SLOTS-1:0] slot_cmp_i,
	input  logic [`FT_NUM_SLOTS-1:0] slot_valid_i,
	input  logic [`FT_NUM_SLOTS-1:0] slot_ready_i,
	input  logic [1:0]               bypass_sel_i,
	output ft_alu_pkg::word_t        result_o,
	output logic                     cmp_o,
	output logic                     out_valid_o,
	output logic                     in_ready_o,
	output logic [`FT_NUM_SLOTS-1:0] slot_err_o,
	output logic                     err_detected_o,
	output logic                     err_corrected_o
);
	import ft_alu_pkg::*;

	word_t                    res_voted;
	logic                     cmp_voted;
	logic                     vld_voted;
	logic [`FT_NUM_SLOTS-1:0] res_mis;
	logic [`FT_NUM_SLOTS-1:0] cmp_mis;
	logic [`FT_NUM_SLOTS-1:0] vld_mis;
	logic [`FT_NUM_SLOTS-1:0] rdy_mis;
	logic                     res_single;
	logic                     cmp_single;
	logic                     vld_single;

	////////////////////////////////////////////////////////////
	// voters
	////////////////////////////////////////////////////////////

	tmr_voter #(.payload_t(word_t)) i_vote_res (
		.in_1_i(slot_result_i[0]), .in_2_i(slot_result_i[1]), .in_3_i(slot_result_i[2]),
		.voted_o(res_voted), .mismatch_o(res_mis)
	);

	tmr_voter #(.payload_t(logic)) i_vote_cmp (
		.in_1_i(slot_cmp_i[0]), .in_2_i(slot_cmp_i[1]), .in_3_i(slot_cmp_i[2]),
		.voted_o(cmp_voted), .mismatch_o(cmp_mis)
	);

	tmr_voter #(.payload_t(logic)) i_vote_vld (
		.in_1_i(slot_valid_i[0]), .in_2_i(slot_valid_i[1]), .in_3_i(slot_valid_i[2]),
		.voted_o(vld_voted), .mismatch_o(vld_mis)
	);

	// ready is always voted and never bypassed
	tmr_voter #(.payload_t(logic)) i_vote_rdy (
		.in_1_i(slot_ready_i[0]), .in_2_i(slot_ready_i[1]), .in_3_i(slot_ready_i[2]),
		.voted_o(in_ready_o), .mismatch_o(rdy_mis)
	);

	////////////////////////////////////////////////////////////
	// bypass
	////////////////////////////////////////////////////////////

	// setting n passes slot n-1 raw
	always_comb begin
		case (bypass_sel_i)
			2'd1: begin
				result_o    = slot_result_i[0];
				cmp_o       = slot_cmp_i[0];
				out_valid_o = slot_valid_i[0];
			end
			2'd2: begin
				result_o    = slot_result_i[1];
				cmp_o       = slot_cmp_i[1];
				out_valid_o = slot_valid_i[1];
			end
			2'd3: begin
				result_o    = slot_result_i[2];
				cmp_o       = slot_cmp_i[2];
				out_valid_o = slot_valid_i[2];
			end
			default: begin
				result_o    = res_voted;
				cmp_o       = cmp_voted;
				out_valid_o = vld_voted;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// error summary
	////////////////////////////////////////////////////////////

	// per slot, any field disagreeing
	assign slot_err_o = res_mis | cmp_mis | vld_mis | rdy_mis;

	// field is correctable when at most one slot disagrees
	assign res_single = (res_mis == '0) || $onehot(res_mis);
	assign cmp_single = (cmp_mis == '0) || $onehot(cmp_mis);
	assign vld_single = (vld_mis == '0) || $onehot(vld_mis);

	assign err_detected_o  = |{res_mis, cmp_mis, vld_mis};
	assign err_corrected_o = err_detected_o & res_single & cmp_single & vld_single;

endmodule

// ==== spare_mux.sv ====
/*
 * slot routing for the voters
 * each slot takes its own replica or the standby replica
 */

`include "ft_alu_config.svh"

module spare_mux (
	input  logic [`FT_NUM_SLOTS-1:0]    spare_sel_i,
	input  ft_alu_pkg::word_t           result_i [`FT_NUM_REPLICAS],
	input  logic [`FT_NUM_REPLICAS-1:0] cmp_i,
	input  logic [`FT_NUM_REPLICAS-1:0] valid_i,
	input  logic [`FT_NUM_REPLICAS-1:0] ready_i,
	output ft_alu_pkg::word_t           slot_result_o [`FT_NUM_SLOTS],
	output logic [`FT_NUM_SLOTS-1:0]    slot_cmp_o,
	output logic [`FT_NUM_SLOTS-1:0]    slot_valid_o,
	output logic [`FT_NUM_SLOTS-1:0]    slot_ready_o
);
	import ft_alu_pkg::*;

	// physical source of every slot
	replica_idx_t slot_src [`FT_NUM_SLOTS];

	for (genvar k = 0; k < `FT_NUM_SLOTS; k++) begin : g_slot
		// standby is the last replica
		assign slot_src[k] = spare_sel_i[k] ?
			replica_idx_t'(`FT_NUM_REPLICAS - 1) : replica_idx_t'(k);

		assign slot_result_o[k] = result_i[slot_src[k]];
		assign slot_cmp_o[k]    = cmp_i[slot_src[k]];
		assign slot_valid_o[k]  = valid_i[slot_src[k]];
		assign slot_ready_o[k]  = ready_i[slot_src[k]];
	end

endmodule

// ==== alu_replica.sv ====
/*
 * single ALU replica with registered result and compare flag
 * valid/ready handshake, one item in flight
 * fault-injection hook on the output register
 */

`include "ft_alu_config.svh"

module alu_replica (
	input  logic                clk,
	input  logic                rst_n_i,
	input  logic                in_valid_i,
	output logic                in_ready_o,
	input  ft_alu_pkg::alu_op_e op_i,
	input  ft_alu_pkg::word_t   operand_a_i,
	input  ft_alu_pkg::word_t   operand_b_i,
	input  ft_alu_pkg::word_t   fault_mask_i,
	input  logic                fault_cmp_i,
	output logic                out_valid_o,
	input  logic                out_ready_i,
	output ft_alu_pkg::word_t   result_o,
	output logic                cmp_o
);
	import ft_alu_pkg::*;

	localparam int SHAMT_W = $clog2(`FT_DATA_WIDTH);

	word_t result_d;
	logic  cmp_d;
	logic  lt_s;
	logic  lt_u;
	logic  load;
	logic  valid_q;
	word_t result_q;
	logic  cmp_q;

	////////////////////////////////////////////////////////////
	// datapath
	////////////////////////////////////////////////////////////

	assign lt_s = $signed(operand_a_i) < $signed(operand_b_i);
	assign lt_u = operand_a_i < operand_b_i;

	always_comb begin
		result_d = '0;
		cmp_d    = operand_a_i == operand_b_i;
		case (op_i)
			ALU_ADD:  result_d = operand_a_i + operand_b_i;
			ALU_SUB:  result_d = operand_a_i - operand_b_i;
			ALU_AND:  result_d = operand_a_i & operand_b_i;
			ALU_OR:   result_d = operand_a_i | operand_b_i;
			ALU_XOR:  result_d = operand_a_i ^ operand_b_i;
			// shift amount from the low bits of b only
			ALU_SLL:  result_d = operand_a_i << operand_b_i[SHAMT_W-1:0];
			ALU_SRL:  result_d = operand_a_i >> operand_b_i[SHAMT_W-1:0];
			ALU_SLT: begin
				result_d = {{(`FT_DATA_WIDTH-1){1'b0}}, lt_s};
				cmp_d    = lt_s;
			end
			ALU_SLTU: begin
				result_d = {{(`FT_DATA_WIDTH-1){1'b0}}, lt_u};
				cmp_d    = lt_u;
			end
			default:  result_d = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// output register and handshake
	////////////////////////////////////////////////////////////

	// free when empty or drained this cycle
	assign in_ready_o = ~valid_q | out_ready_i;
	assign load       = in_valid_i & in_ready_o;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q <= 1'b0;
		end else if (load) begin
			valid_q <= 1'b1;
		end else if (out_ready_i) begin
			valid_q <= 1'b0;
		end
	end

	// upset lands in the register as it is written
	always_ff @(posedge clk) begin
		if (load) begin
			result_q <= result_d ^ fault_mask_i;
			cmp_q    <= cmp_d ^ fault_cmp_i;
		end
	end

	assign out_valid_o = valid_q;
	assign result_o    = result_q;
	assign cmp_o       = cmp_q;

endmodule

// ==== tmr_voter.sv ====
/*
 * 2-of-3 bitwise majority voter
 * payload type is a parameter, one mismatch flag per input
 */

`include "ft_alu_config.svh"

module tmr_voter #(
	parameter type payload_t = logic
) (
	input  payload_t                in_1_i,
	input  payload_t                in_2_i,
	input  payload_t                in_3_i,
	output payload_t                voted_o,
	output logic [`FT_NUM_SLOTS-1:0] mismatch_o
);

	////////////////////////////////////////////////////////////
	// majority
	////////////////////////////////////////////////////////////

	// any two agreeing bits win
	assign voted_o = (in_1_i & in_2_i) |
		(in_1_i & in_3_i) |
		(in_2_i & in_3_i);

	////////////////////////////////////////////////////////////
	// disagreement per input
	////////////////////////////////////////////////////////////

	// input differs from the voted value in at least one bit
	assign mismatch_o[0] = in_1_i != voted_o;
	assign mismatch_o[1] = in_2_i != voted_o;
	assign mismatch_o[2] = in_3_i != voted_o;

endmodule

// ==== ft_alu_pkg.sv ====
/*
 * shared types for the fault-tolerant ALU stage
 * operation enum, data word, replica index, error counter
 */

`include "ft_alu_config.svh"

package ft_alu_pkg;

	////////////////////////////////////////////////////////////
	// operation codes
	////////////////////////////////////////////////////////////

	// reduced set, no vector or complex modes
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_SLL  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SLT  = 4'd7,
		ALU_SLTU = 4'd8
	} alu_op_e;

	////////////////////////////////////////////////////////////
	// data and bookkeeping types
	////////////////////////////////////////////////////////////

	typedef logic [`FT_DATA_WIDTH-1:0] word_t;

	// physical replica number, 0 to 3
	typedef logic [1:0] replica_idx_t;

	typedef logic [`FT_ERR_CNT_WIDTH-1:0] err_cnt_t;

endpackage

// ==== ft_alu_config.svh ====
/*
 * width, replica count and slot count macros
 * error counter width and permanent-fault threshold
 */

`ifndef FT_ALU_CONFIG_SVH
`define FT_ALU_CONFIG_SVH

// operand and result width
`define FT_DATA_WIDTH 32

// four physical replicas feed three voting slots
`define FT_NUM_REPLICAS 4
`define FT_NUM_SLOTS 3

// per-replica error counters
`define FT_ERR_CNT_WIDTH 8
`define FT_FAULT_THRESHOLD 4

`endif
